// File: rtl/cache_geom_pkg.sv
// Geometry defaults and derived widths of the L1 data cache and its write-back buffer
package cache_geom_pkg;

  // Set index width
  // 4 bits gives 16 direct-mapped sets
  localparam int unsigned IDX_LEN_DEF = 4;

  // Tag width kept next to each set
  localparam int unsigned TAG_LEN_DEF = 6;

  // One-word line
  localparam int unsigned DATA_W_DEF = 32;

  // Entries in the write-back buffer
  localparam int unsigned WBB_DEPTH_DEF = 4;

  // L2 line address is {tag, index}
  // Tag sits in the upper bits, set index in the lower bits
  localparam int unsigned ADDR_W_DEF = TAG_LEN_DEF + IDX_LEN_DEF;

  // Number of sets at the default index width
  localparam int unsigned NUM_SETS_DEF = 2 ** IDX_LEN_DEF;

endpackage

// File: rtl/cache_ctrl_pkg.sv
// Controller state and evict opcode enums for the L1-to-L2 synchronization path
package cache_ctrl_pkg;

  // Update controller states
  // Idle until a sync pulse, then walk the sets, then drain the buffer
  typedef enum logic [1:0] {
    upd_idle     = 2'b00,
    upd_updating = 2'b01,
    upd_wait_buf = 2'b10,
    upd_done     = 2'b11
  } upd_state_e;

  // Evict decision for the set being looked at
  // Push only for a line that is both valid and dirty
  typedef enum logic {
    evict_skip = 1'b0,
    evict_push = 1'b1
  } evict_op_e;

endpackage

// File: rtl/l2_update_ctrl.sv
// Set counter and FSM that sequence a full L1-to-L2 synchronization
`timescale 1ns/10ps

module l2_update_ctrl #(
  parameter int unsigned IDX_LEN = cache_geom_pkg::IDX_LEN_DEF
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sync request from the system
  input  logic               synch_i,
  // Set accepted by the evict stage
  input  logic               en_cnt_i,
  // Write-back buffer has drained
  input  logic               wbb_empty_i,
  // Read request to the lookup stage
  output logic               upd_valid_o,
  output logic [IDX_LEN-1:0] upd_idx_o,
  // One-cycle completion pulse
  output logic               done_o
);

  cache_ctrl_pkg::upd_state_e state_d, state_q;

  logic [IDX_LEN-1:0] cnt_q;
  // Terminal count, last set addressed
  logic               tc;

  // Set counter
  // Advances only on an accepted set while updating
  // Wraps to zero after the last set, ready for the next sync
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (en_cnt_i && state_q == cache_ctrl_pkg::upd_updating) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tc        = &cnt_q;
  assign upd_idx_o = cnt_q;

  // Next state and Moore outputs
  always_comb begin
    state_d     = state_q;
    upd_valid_o = 1'b0;
    done_o      = 1'b0;
    case (state_q)
      cache_ctrl_pkg::upd_idle: begin
        // Sync only honoured here
        if (synch_i) begin
          state_d = cache_ctrl_pkg::upd_updating;
        end
      end
      cache_ctrl_pkg::upd_updating: begin
        upd_valid_o = 1'b1;
        // Last set accepted, wait for pushed lines to reach L2
        if (tc && en_cnt_i) begin
          state_d = cache_ctrl_pkg::upd_wait_buf;
        end
      end
      cache_ctrl_pkg::upd_wait_buf: begin
        if (wbb_empty_i) begin
          state_d = cache_ctrl_pkg::upd_done;
        end
      end
      cache_ctrl_pkg::upd_done: begin
        done_o  = 1'b1;
        state_d = cache_ctrl_pkg::upd_idle;
      end
      default: state_d = cache_ctrl_pkg::upd_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= cache_ctrl_pkg::upd_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Evict stage accepts sets only during the walk
  a_en_cnt_only_updating : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    en_cnt_i |-> state_q == cache_ctrl_pkg::upd_updating
  ) else $error("en_cnt_i high outside the updating state");

endmodule

// File: rtl/l1dc_lookup_stage.sv
// L1 tag, valid, dirty and data arrays with store port, index read and dirty clear
`timescale 1ns/10ps

module l1dc_lookup_stage #(
  parameter int unsigned IDX_LEN = cache_geom_pkg::IDX_LEN_DEF,
  parameter int unsigned TAG_LEN = cache_geom_pkg::TAG_LEN_DEF,
  parameter int unsigned DATA_W  = cache_geom_pkg::DATA_W_DEF
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Store port, whole one-word line
  input  logic               st_en_i,
  input  logic [IDX_LEN-1:0] st_idx_i,
  input  logic [TAG_LEN-1:0] st_tag_i,
  input  logic [DATA_W-1:0]  st_data_i,
  // Set read from the update controller
  input  logic               rd_en_i,
  input  logic [IDX_LEN-1:0] rd_idx_i,
  // Dirty clear from the evict stage
  input  logic               clr_i,
  input  logic [IDX_LEN-1:0] clr_idx_i,
  // Addressed set to the evict stage
  output logic               rd_valid_o,
  output logic               line_valid_o,
  output logic               line_dirty_o,
  output logic [TAG_LEN-1:0] line_tag_o,
  output logic [DATA_W-1:0]  line_data_o
);

  localparam int unsigned NUM_SETS = 2 ** IDX_LEN;

  // Status bits per set
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;

  // Payload arrays
  logic [TAG_LEN-1:0]  tag_mem  [NUM_SETS];
  logic [DATA_W-1:0]   data_mem [NUM_SETS];

  // Valid and dirty
  // A store marks the line valid and dirty
  // A clear drops dirty only, the line stays valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (clr_i) begin
        dirty_q[clr_idx_i] <= 1'b0;
      end
      // Store last, so it wins on a shared index
      if (st_en_i) begin
        valid_q[st_idx_i] <= 1'b1;
        dirty_q[st_idx_i] <= 1'b1;
      end
    end
  end

  // Tag and data written together on a store
  always_ff @(posedge clk_i) begin
    if (st_en_i) begin
      tag_mem[st_idx_i]  <= st_tag_i;
      data_mem[st_idx_i] <= st_data_i;
    end
  end

  // Zero-latency read of the addressed set
  assign rd_valid_o   = rd_en_i;
  assign line_valid_o = valid_q[rd_idx_i];
  assign line_dirty_o = dirty_q[rd_idx_i];
  assign line_tag_o   = tag_mem[rd_idx_i];
  assign line_data_o  = data_mem[rd_idx_i];

  // No stores while a sync walks the sets
  a_no_store_during_read : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(st_en_i && rd_en_i)
  ) else $error("Store and sync read in the same cycle");

  // Evict stage only clears a line that is still dirty
  a_clr_dirty_line : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    clr_i |-> (valid_q[clr_idx_i] && dirty_q[clr_idx_i])
  ) else $error("Dirty clear on a clean or invalid set %0d", clr_idx_i);

endmodule

// File: rtl/l1dc_evict_stage.sv
// Per-set push decision, write-back buffer write and count-enable strobe
`timescale 1ns/10ps

module l1dc_evict_stage #(
  parameter int unsigned IDX_LEN = cache_geom_pkg::IDX_LEN_DEF,
  parameter int unsigned TAG_LEN = cache_geom_pkg::TAG_LEN_DEF,
  parameter int unsigned DATA_W  = cache_geom_pkg::DATA_W_DEF
) (
  // Addressed set from the lookup stage
  input  logic                       rd_valid_i,
  input  logic                       line_valid_i,
  input  logic                       line_dirty_i,
  input  logic [TAG_LEN-1:0]         line_tag_i,
  input  logic [DATA_W-1:0]          line_data_i,
  input  logic [IDX_LEN-1:0]         rd_idx_i,
  // Buffer back-pressure
  input  logic                       wbb_full_i,
  // Advance the set counter
  output logic                       en_cnt_o,
  // Dirty clear back to the lookup stage
  output logic                       clr_o,
  output logic [IDX_LEN-1:0]         clr_idx_o,
  // Line into the write-back buffer
  output logic                       push_o,
  output logic [TAG_LEN+IDX_LEN-1:0] push_addr_o,
  output logic [DATA_W-1:0]          push_data_o
);

  cache_ctrl_pkg::evict_op_e op;
  logic                      accept;

  always_comb begin
    // Opcode for the current set
    if (line_valid_i && line_dirty_i) begin
      op = cache_ctrl_pkg::evict_push;
    end else begin
      op = cache_ctrl_pkg::evict_skip;
    end

    // Skip goes through at once
    // Push waits for a free buffer slot, set is re-read meanwhile
    accept = rd_valid_i &&
             (op == cache_ctrl_pkg::evict_skip || !wbb_full_i);

    en_cnt_o = accept;
    push_o   = accept && (op == cache_ctrl_pkg::evict_push);

    // Pushed line is clean from the next cycle on
    clr_o     = push_o;
    clr_idx_o = rd_idx_i;

    // L2 address {tag, index}
    push_addr_o = {line_tag_i, rd_idx_i};
    push_data_o = line_data_i;
  end

endmodule

// File: rtl/wb_buffer.sv
// Circular write-back FIFO draining to the L2 write port under busy back-pressure
`timescale 1ns/10ps

module wb_buffer #(
  parameter int unsigned WBB_DEPTH = cache_geom_pkg::WBB_DEPTH_DEF,
  parameter int unsigned ADDR_W    = cache_geom_pkg::ADDR_W_DEF,
  parameter int unsigned DATA_W    = cache_geom_pkg::DATA_W_DEF
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Line from the evict stage
  input  logic              push_i,
  input  logic [ADDR_W-1:0] push_addr_i,
  input  logic [DATA_W-1:0] push_data_i,
  // L2 cannot take a write
  input  logic              l2_busy_i,
  // Occupancy flags
  output logic              full_o,
  output logic              empty_o,
  // L2 write port
  output logic              l2_wr_o,
  output logic [ADDR_W-1:0] l2_addr_o,
  output logic [DATA_W-1:0] l2_data_o
);

  localparam int unsigned PTR_W = (WBB_DEPTH > 1) ? $clog2(WBB_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(WBB_DEPTH + 1);

  logic [ADDR_W-1:0] addr_mem [WBB_DEPTH];
  logic [DATA_W-1:0] data_mem [WBB_DEPTH];

  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              wr_en;
  logic              pop;

  // Pointer step with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(WBB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign full_o  = (count_q == CNT_W'(WBB_DEPTH));
  assign empty_o = (count_q == '0);

  assign wr_en = push_i && !full_o;
  // Head leaves whenever L2 is free
  assign pop   = !empty_o && !l2_busy_i;

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      addr_mem[wr_ptr_q] <= push_addr_i;
      data_mem[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({wr_en, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head entry straight onto the L2 port
  assign l2_wr_o   = pop;
  assign l2_addr_o = addr_mem[rd_ptr_q];
  assign l2_data_o = data_mem[rd_ptr_q];

  // Evict stage holds off while full
  a_no_push_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o
  ) else $error("Push into a full write-back buffer");

endmodule

// File: rtl/l1dc_sync_top.sv
// Top level of the L1 clean-back path joining controller, lookup, evict and buffer
`timescale 1ns/10ps

module l1dc_sync_top #(
  parameter int unsigned IDX_LEN   = cache_geom_pkg::IDX_LEN_DEF,
  parameter int unsigned TAG_LEN   = cache_geom_pkg::TAG_LEN_DEF,
  parameter int unsigned DATA_W    = cache_geom_pkg::DATA_W_DEF,
  parameter int unsigned WBB_DEPTH = cache_geom_pkg::WBB_DEPTH_DEF
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Sync request and completion
  input  logic                       synch_i,
  output logic                       l2c_update_done_o,
  // Store port
  input  logic                       st_en_i,
  input  logic [IDX_LEN-1:0]         st_idx_i,
  input  logic [TAG_LEN-1:0]         st_tag_i,
  input  logic [DATA_W-1:0]          st_data_i,
  // L2 write port
  output logic                       l2_wr_o,
  output logic [TAG_LEN+IDX_LEN-1:0] l2_addr_o,
  output logic [DATA_W-1:0]          l2_data_o,
  input  logic                       l2_busy_i
);

  localparam int unsigned ADDR_W = TAG_LEN + IDX_LEN;

  // Controller to lookup
  logic               upd_valid;
  logic [IDX_LEN-1:0] upd_idx;
  // Lookup to evict
  logic               rd_valid;
  logic               line_valid;
  logic               line_dirty;
  logic [TAG_LEN-1:0] line_tag;
  logic [DATA_W-1:0]  line_data;
  // Evict back to lookup and controller
  logic               en_cnt;
  logic               dirty_clr;
  logic [IDX_LEN-1:0] clr_idx;
  // Evict to buffer and back
  logic               wbb_push;
  logic [ADDR_W-1:0]  wbb_addr;
  logic [DATA_W-1:0]  wbb_data;
  logic               wbb_full;
  logic               wbb_empty;

  l2_update_ctrl #(.IDX_LEN(IDX_LEN)) l2_update_ctrl_i (
    .clk_i, .rst_ni, .synch_i, .en_cnt_i(en_cnt), .wbb_empty_i(wbb_empty),
    .upd_valid_o(upd_valid), .upd_idx_o(upd_idx), .done_o(l2c_update_done_o)
  );

  l1dc_lookup_stage #(.IDX_LEN(IDX_LEN), .TAG_LEN(TAG_LEN), .DATA_W(DATA_W))
  l1dc_lookup_stage_i (
    .clk_i, .rst_ni, .st_en_i, .st_idx_i, .st_tag_i, .st_data_i,
    .rd_en_i(upd_valid), .rd_idx_i(upd_idx), .clr_i(dirty_clr), .clr_idx_i(clr_idx),
    .rd_valid_o(rd_valid), .line_valid_o(line_valid), .line_dirty_o(line_dirty),
    .line_tag_o(line_tag), .line_data_o(line_data)
  );

  l1dc_evict_stage #(.IDX_LEN(IDX_LEN), .TAG_LEN(TAG_LEN), .DATA_W(DATA_W))
  l1dc_evict_stage_i (
    .rd_valid_i(rd_valid), .line_valid_i(line_valid), .line_dirty_i(line_dirty),
    .line_tag_i(line_tag), .line_data_i(line_data), .rd_idx_i(upd_idx),
    .wbb_full_i(wbb_full), .en_cnt_o(en_cnt), .clr_o(dirty_clr), .clr_idx_o(clr_idx),
    .push_o(wbb_push), .push_addr_o(wbb_addr), .push_data_o(wbb_data)
  );

  wb_buffer #(.WBB_DEPTH(WBB_DEPTH), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) wb_buffer_i (
    .clk_i, .rst_ni, .push_i(wbb_push), .push_addr_i(wbb_addr), .push_data_i(wbb_data),
    .l2_busy_i, .full_o(wbb_full), .empty_o(wbb_empty),
    .l2_wr_o, .l2_addr_o, .l2_data_o
  );

endmodule

// File: sim/tb_l1dc_sync.sv
// Testbench for the L1 clean-back path with LFSR stimulus, shadow L1 model and SVA checks
`timescale 1ns/10ps

module tb_l1dc_sync;

  localparam int unsigned IDX_LEN   = cache_geom_pkg::IDX_LEN_DEF;
  localparam int unsigned TAG_LEN   = cache_geom_pkg::TAG_LEN_DEF;
  localparam int unsigned DATA_W    = cache_geom_pkg::DATA_W_DEF;
  localparam int unsigned WBB_DEPTH = cache_geom_pkg::WBB_DEPTH_DEF;
  localparam int unsigned ADDR_W    = TAG_LEN + IDX_LEN;
  localparam int unsigned NUM_SETS  = 2 ** IDX_LEN;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned RST_CYC    = 16;
  // Longest busy run of the L2 model
  localparam int unsigned MAX_BUSY   = 16;
  localparam int unsigned N_SYNCS    = 5;
  // Quiet cycles after done, long enough for a second walk to show up
  localparam int unsigned TAIL_CYC   = NUM_SETS + 8;
  // Each line may wait out one full busy run, plus the walk and the tail
  localparam int unsigned SYNC_CYC   = NUM_SETS * (MAX_BUSY + 1) + NUM_SETS + 8 + TAIL_CYC;
  localparam int unsigned STORE_CYC  = 6 * NUM_SETS;
  localparam int unsigned WATCHDOG_CYC = RST_CYC + STORE_CYC + N_SYNCS * SYNC_CYC + 64;

  logic              clk;
  logic              rst_n;
  logic              synch;
  logic              update_done;
  logic              st_en;
  logic [IDX_LEN-1:0] st_idx;
  logic [TAG_LEN-1:0] st_tag;
  logic [DATA_W-1:0] st_data;
  logic              l2_wr;
  logic [ADDR_W-1:0] l2_addr;
  logic [DATA_W-1:0] l2_data;
  logic              l2_busy;

  // Shadow of the L1 arrays
  logic [TAG_LEN-1:0] sh_tag  [NUM_SETS];
  logic [DATA_W-1:0]  sh_data [NUM_SETS];
  logic [NUM_SETS-1:0] sh_dirty;

  // Expected L2 writes, oldest first
  logic [ADDR_W-1:0] exp_addr_q [$];
  logic [DATA_W-1:0] exp_data_q [$];
  // Head of the expected queue
  logic              exp_pending;
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] exp_data;

  logic        in_sync;
  int          done_cnt;
  logic [15:0] lfsr;
  // L2 busy generator
  logic        busy_en;
  int          busy_left;
  int          value_errs;
  int          proto_errs;

  l1dc_sync_top #(
    .IDX_LEN(IDX_LEN), .TAG_LEN(TAG_LEN), .DATA_W(DATA_W), .WBB_DEPTH(WBB_DEPTH)
  ) l1dc_sync_top_i (
    .clk_i(clk), .rst_ni(rst_n), .synch_i(synch), .l2c_update_done_o(update_done),
    .st_en_i(st_en), .st_idx_i(st_idx), .st_tag_i(st_tag), .st_data_i(st_data),
    .l2_wr_o(l2_wr), .l2_addr_o(l2_addr), .l2_data_o(l2_data), .l2_busy_i(l2_busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Nothing reaches L2 and no done pulse between syncs
  a_quiet_outside_sync : assert property (@(posedge clk) disable iff (!rst_n)
    !in_sync |-> (!l2_wr && !update_done)
  ) else begin
    proto_errs = proto_errs + 1;
    $display("L2 write or done pulse outside a sync at %0t", $time);
  end

  a_write_expected : assert property (@(posedge clk) disable iff (!rst_n)
    l2_wr |-> exp_pending
  ) else begin
    proto_errs = proto_errs + 1;
    $display("L2 write with no dirty line left to write back at %0t", $time);
  end

  // Ascending set order falls out of the queue order
  a_addr_match : assert property (@(posedge clk) disable iff (!rst_n)
    (l2_wr && exp_pending) |-> (l2_addr == exp_addr)
  ) else begin
    value_errs = value_errs + 1;
    $display("[FAIL] l2_addr_o got 0x%h expected 0x%h", $sampled(l2_addr),
             $sampled(exp_addr));
  end

  a_data_match : assert property (@(posedge clk) disable iff (!rst_n)
    (l2_wr && exp_pending) |-> (l2_data == exp_data)
  ) else begin
    value_errs = value_errs + 1;
    $display("[FAIL] l2_data_o got 0x%h expected 0x%h", $sampled(l2_data),
             $sampled(exp_data));
  end

  a_no_write_busy : assert property (@(posedge clk) disable iff (!rst_n)
    l2_busy |-> !l2_wr
  ) else begin
    proto_errs = proto_errs + 1;
    $display("L2 write while L2 was busy at %0t", $time);
  end

  a_single_done : assert property (@(posedge clk) disable iff (!rst_n)
    update_done |-> (done_cnt == 0)
  ) else begin
    proto_errs = proto_errs + 1;
    $display("Second done pulse within one sync at %0t", $time);
  end

  // Done only once every dirty line has gone out
  a_done_after_writes : assert property (@(posedge clk) disable iff (!rst_n)
    update_done |-> !exp_pending
  ) else begin
    proto_errs = proto_errs + 1;
    $display("Done pulse with dirty lines still missing at %0t", $time);
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic refresh_head();
    exp_pending = (exp_addr_q.size() != 0);
    if (exp_pending) begin
      exp_addr = exp_addr_q[0];
      exp_data = exp_data_q[0];
    end
  endtask

  // Busy runs of 1..16 cycles alternate with free runs of 1..4
  task automatic step_busy();
    logic [31:0] v;
    if (!busy_en) begin
      l2_busy = 1'b0;
      busy_left = 0;
    end else if (busy_left == 0) begin
      if (l2_busy) begin
        draw(2, v);
        busy_left = int'(v[1:0]);
        l2_busy = 1'b0;
      end else begin
        draw(4, v);
        busy_left = int'(v[3:0]);
        l2_busy = 1'b1;
      end
    end else begin
      busy_left = busy_left - 1;
    end
  endtask

  // Outputs sampled once settled, queue updated on the next falling edge
  task automatic tick();
    logic wr_now;
    logic done_now;
    #1;
    wr_now = l2_wr;
    done_now = update_done;
    @(negedge clk);
    if (wr_now && exp_addr_q.size() != 0) begin
      void'(exp_addr_q.pop_front());
      void'(exp_data_q.pop_front());
    end
    if (done_now) begin
      done_cnt = done_cnt + 1;
    end
    refresh_head();
    step_busy();
  endtask

  task automatic store_line(input logic [IDX_LEN-1:0] idx, input logic [TAG_LEN-1:0] tag,
                            input logic [DATA_W-1:0] data);
    st_en = 1'b1;
    st_idx = idx;
    st_tag = tag;
    st_data = data;
    sh_tag[idx] = tag;
    sh_data[idx] = data;
    sh_dirty[idx] = 1'b1;
    tick();
    st_en = 1'b0;
  endtask

  // Random sets, repeats overwrite an earlier store
  task automatic store_random(input int n);
    logic [31:0] idx_v;
    logic [31:0] tag_v;
    logic [31:0] data_v;
    for (int i = 0; i < n; i++) begin
      draw(IDX_LEN, idx_v);
      draw(TAG_LEN, tag_v);
      draw(DATA_W, data_v);
      store_line(idx_v[IDX_LEN-1:0], tag_v[TAG_LEN-1:0], data_v[DATA_W-1:0]);
    end
  endtask

  task automatic store_all();
    logic [31:0] tag_v;
    logic [31:0] data_v;
    for (int i = 0; i < NUM_SETS; i++) begin
      draw(TAG_LEN, tag_v);
      draw(DATA_W, data_v);
      store_line(IDX_LEN'(i), tag_v[TAG_LEN-1:0], data_v[DATA_W-1:0]);
    end
  endtask

  // Every dirty set in ascending order, then all clean
  task automatic queue_dirty_lines();
    for (int i = 0; i < NUM_SETS; i++) begin
      if (sh_dirty[i]) begin
        exp_addr_q.push_back({sh_tag[i], IDX_LEN'(i)});
        exp_data_q.push_back(sh_data[i]);
      end
    end
    sh_dirty = '0;
    refresh_head();
  endtask

  // Sync pulse, optional stray pulse extra_at cycles later, wait for done
  task automatic run_sync(input int extra_at);
    int cyc;
    queue_dirty_lines();
    done_cnt = 0;
    in_sync = 1'b1;
    synch = 1'b1;
    tick();
    synch = 1'b0;
    cyc = 0;
    while (done_cnt == 0) begin
      tick();
      cyc = cyc + 1;
      synch = (cyc == extra_at);
    end
    synch = 1'b0;
    in_sync = 1'b0;
    repeat (TAIL_CYC) tick();
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    synch = 1'b0;
    st_en = 1'b0;
    st_idx = '0;
    st_tag = '0;
    st_data = '0;
    l2_busy = 1'b0;
    busy_en = 1'b0;
    busy_left = 0;
    in_sync = 1'b0;
    done_cnt = 0;
    lfsr = 16'd28255;
    sh_dirty = '0;
    exp_pending = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    value_errs = 0;
    proto_errs = 0;
    repeat (RST_CYC) tick();
    rst_n = 1'b1;
    // Idle after reset, L2 side must stay quiet
    repeat (8) tick();
    // Clean cache, done alone
    run_sync(0);
    store_random(24);
    run_sync(0);
    // Dirty bits already cleared
    run_sync(0);
    // Full buffer and long busy runs
    store_all();
    busy_en = 1'b1;
    run_sync(0);
    busy_en = 1'b0;
    store_random(8);
    run_sync(3);
    $display("Error counts: value %0d, protocol %0d", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout, the run did not finish in %0d cycles", WATCHDOG_CYC);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: sources.f
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/l2_update_ctrl.sv
rtl/l1dc_lookup_stage.sv
rtl/l1dc_evict_stage.sv
rtl/wb_buffer.sv
rtl/l1dc_sync_top.sv
sim/tb_l1dc_sync.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_l1dc_sync \
  --Mdir obj_dir -o tb_l1dc_sync

out=$(./obj_dir/tb_l1dc_sync)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi
